//--- filelist.f
+incdir+rtl
rtl/conv_types_pkg.sv
rtl/conv_ctrl_pkg.sv
rtl/row_fetch.sv
rtl/line_ring.sv
rtl/window_emit.sv
rtl/conv_datapath_front.sv
dv/conv_dp_front_sva.sv
dv/conv_dp_front_tb.sv

//--- run.sh
#!/usr/bin/env bash
# Compile with Verilator, run, and look for the pass line in the output

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -Wno-fatal --timescale 1ns/1ps \
    --top-module conv_dp_front_tb -f filelist.f \
    && ./obj_dir/Vconv_dp_front_tb | tee /dev/stderr | grep -q '^>>> PASS$' \
    && echo "run.sh: simulation passed" \
    || { echo "run.sh: simulation failed"; exit 1; }

//--- dv/conv_dp_front_tb.sv
`include "conv_front_settings.svh"

module conv_dp_front_tb;
    timeunit 1ns;
    timeprecision 1ps;

    import conv_types_pkg::*;
    import conv_ctrl_pkg::*;

    localparam int CLK_PERIOD = 40;
    localparam int DRIVE_DELAY = 2;
    localparam int RESET_CYCLES = 16;
    localparam logic [31:0] LCG_SEED = 32'd784;
    localparam int NUM_RUNS = 7;

    // One entry per start pulse
    localparam int RUN_IY[NUM_RUNS] = '{8, 8, 9, 9, 3, 7, 11};
    localparam int RUN_S[NUM_RUNS] = '{1, 1, 2, 2, 1, 1, 2};
    localparam int RUN_P[NUM_RUNS] = '{0, 1, 0, 1, 0, 1, 0};
    // Zero idle, next start right after done
    localparam int RUN_IDLE[NUM_RUNS] = '{3, 3, 3, 3, 6, 0, 3};
    string run_names[NUM_RUNS] = '{"s1_p0_iy8", "s1_p1_iy8", "s2_p0_iy9", "s2_p1_iy9",
                                   "min_iy3", "b2b_first", "b2b_second"};

    // DUT ports
    logic clk;
    logic rst_n;
    logic start;
    conv_cfg_t cfg;
    row_t mem_rdata;
    logic mem_rd;
    logic [`CONV_DIM_BITS-1:0] mem_addr;
    window_t win;
    logic win_valid;
    logic busy;
    logic done;

    // Run bookkeeping
    logic [31:0] mem_salt;
    conv_cfg_t run_cfg;
    int run_oy;
    int win_count;
    int error_count;
    int check_count;
    // Memory read seen before the edge
    logic rd_seen;
    row_t rd_data;

    conv_datapath_front dut0 (
        .clk       (clk),
        .rst_n     (rst_n),
        .start     (start),
        .cfg       (cfg),
        .mem_rdata (mem_rdata),
        .mem_rd    (mem_rd),
        .mem_addr  (mem_addr),
        .win       (win),
        .win_valid (win_valid),
        .busy      (busy),
        .done      (done)
    );

    //////////////////////////////
    // Reference model
    //////////////////////////////

    function automatic logic [31:0] lcg_next(input logic [31:0] state);
        return state * 32'd1103515245 + 32'd12345;
    endfunction

    // Pixel hashed from run salt, row and column
    function automatic pixel_t pixel_at(input int row, input int col);
        logic [31:0] h;
        h = lcg_next(LCG_SEED + mem_salt);
        h = lcg_next(h ^ (32'(row) << 8) ^ 32'(col));
        h = lcg_next(h);
        return h[23:16];
    endfunction

    function automatic row_t row_word(input int row);
        row_t r;
        for (int c = 0; c < `CONV_ROW_PIXELS; c++) begin
            r[c] = pixel_at(row, c);
        end
        return r;
    endfunction

    // Rows outside 0..iy-1 are zero
    function automatic row_t padded_row(input int row, input int iy);
        if (row < 0 || row >= iy) begin
            return '0;
        end
        return row_word(row);
    endfunction

    function automatic int expected_oy(input int iy, input int s, input int p);
        return (iy + 2 * p - 3) / s + 1;
    endfunction

    // Window o uses rows o*s-p up to o*s-p+2
    function automatic window_t expected_window(input int o, input conv_cfg_t c);
        window_t w;
        int s;
        int first;
        s = (c.stride == stride_two) ? 2 : 1;
        first = o * s - int'(c.pad);
        w.top = padded_row(first, int'(c.iy));
        w.mid = padded_row(first + 1, int'(c.iy));
        w.bot = padded_row(first + 2, int'(c.iy));
        w.out_row = `CONV_DIM_BITS'(o);
        return w;
    endfunction

    //////////////////////////////
    // Compare tasks
    //////////////////////////////

    task automatic report_mismatch(input string sig, input row_t exp, input row_t got);
        error_count++;
        $display("FAILED at %0t: %s expected %h, got %h", $time, sig, exp, got);
    endtask

    task automatic check_window(input window_t exp, input window_t got);
        check_count++;
        if (got.top !== exp.top) begin
            report_mismatch("win.top", exp.top, got.top);
        end
        if (got.mid !== exp.mid) begin
            report_mismatch("win.mid", exp.mid, got.mid);
        end
        if (got.bot !== exp.bot) begin
            report_mismatch("win.bot", exp.bot, got.bot);
        end
        if (got.out_row !== exp.out_row) begin
            report_mismatch("win.out_row", row_t'(exp.out_row), row_t'(got.out_row));
        end
    endtask

    task automatic check_done(input logic [`CONV_DIM_BITS-1:0] exp,
                              input logic [`CONV_DIM_BITS-1:0] got);
        check_count++;
        if (got !== exp) begin
            error_count++;
            $display("FAILED at %0t: window count at done expected %0d, got %0d",
                     $time, exp, got);
        end
    endtask

    //////////////////////////////
    // Clock and memory model
    //////////////////////////////

    initial begin
        clk = 1'b0;
        forever #(CLK_PERIOD / 2) clk = ~clk;
    end

    // Address is stable mid-cycle
    always @(negedge clk) begin
        rd_seen = mem_rd;
        if (mem_rd) begin
            rd_data = row_word(int'(mem_addr));
        end
    end

    // Data returns one cycle after the read
    always begin
        @(posedge clk);
        #DRIVE_DELAY;
        if (rd_seen) begin
            mem_rdata = rd_data;
        end
    end

    // Every window against the reference, in order
    always @(negedge clk) begin
        if (rst_n && win_valid) begin
            if (win_count >= run_oy) begin
                error_count++;
                $display("Unexpected window at %0t after all %0d windows of the run",
                         $time, run_oy);
            end else begin
                check_window(expected_window(win_count, run_cfg), win);
            end
            win_count++;
        end
    end

    //////////////////////////////
    // Stimulus
    //////////////////////////////

    task automatic run_test(input int idx);
        conv_cfg_t c;
        c.iy = `CONV_DIM_BITS'(RUN_IY[idx]);
        c.stride = (RUN_S[idx] == 2) ? stride_two : stride_one;
        c.pad = (RUN_P[idx] != 0);
        @(posedge clk);
        #DRIVE_DELAY;
        // Fresh memory contents per run
        mem_salt = 32'(idx + 1) * 32'h9e37;
        run_cfg = c;
        run_oy = expected_oy(RUN_IY[idx], RUN_S[idx], RUN_P[idx]);
        win_count = 0;
        cfg = c;
        start = 1'b1;
        @(posedge clk);
        #DRIVE_DELAY;
        start = 1'b0;
        // Config must be held internally
        cfg = '0;
        // Busy from the cycle after start through the done pulse
        do begin
            @(negedge clk);
            if (!busy) begin
                error_count++;
                $display("busy is low at %0t while run %0d is still going", $time, idx);
            end
        end while (!done);
        check_done(`CONV_DIM_BITS'(run_oy), `CONV_DIM_BITS'(win_count));
        // Quiet after done
        repeat (RUN_IDLE[idx]) begin
            @(negedge clk);
            if (busy) begin
                error_count++;
                $display("busy is still high at %0t after done of run %0d", $time, idx);
            end
        end
    endtask

    initial begin : main_flow
        int errors_before;
        int failed_runs;
        $timeformat(-9, 0, " ns", 0);
        rst_n = 1'b0;
        start = 1'b0;
        cfg = '0;
        mem_rdata = '0;
        mem_salt = '0;
        run_cfg = '0;
        run_oy = 0;
        win_count = 0;
        error_count = 0;
        check_count = 0;
        failed_runs = 0;
        repeat (RESET_CYCLES) @(posedge clk);
        #DRIVE_DELAY;
        rst_n = 1'b1;
        for (int i = 0; i < NUM_RUNS; i++) begin
            errors_before = error_count;
            run_test(i);
            if (error_count != errors_before) begin
                failed_runs++;
            end
            $display("test %0d %s finished: %0d of %0d windows, %0d errors", i,
                     run_names[i], win_count, run_oy, error_count - errors_before);
        end
        $display("runs %0d, failed runs %0d, checks %0d, errors %0d",
                 NUM_RUNS, failed_runs, check_count, error_count);
        if (error_count == 0) begin
            $display(">>> PASS");
        end else begin
            $display(">>> FAIL");
        end
        $finish;
    end

    // Budget of iy + 2*oy + 20 cycles per run
    initial begin : watchdog
        int limit_ns;
        limit_ns = RESET_CYCLES * CLK_PERIOD;
        for (int i = 0; i < NUM_RUNS; i++) begin
            limit_ns += (RUN_IY[i] + 2 * expected_oy(RUN_IY[i], RUN_S[i], RUN_P[i]) + 20
                         + RUN_IDLE[i]) * CLK_PERIOD;
        end
        #(limit_ns);
        $display("Watchdog expired at %0t, the runs did not all reach done", $time);
        $display(">>> FAIL");
        $finish;
    end

endmodule

//--- dv/conv_dp_front_sva.sv
`include "conv_front_settings.svh"

module conv_dp_front_sva (
    input logic                                 clk,
    input logic                                 rst_n,
    input logic                                 mem_rd,
    input logic                                 push,
    input logic [$clog2(`CONV_RING_ROWS+1)-1:0] count,
    input logic                                 win_valid,
    input logic                                 done,
    input logic                                 busy
);
    timeunit 1ns;
    timeprecision 1ps;

    //////////////////////////////
    // Output pulses
    //////////////////////////////

    // Last window and end of run fall in different cycles
    win_not_done: assert property (@(posedge clk) disable iff (!rst_n)
        !(win_valid && done))
        else $error("win_valid and done high in the same cycle");

    // Run ends with busy dropping
    done_drops_busy: assert property (@(posedge clk) disable iff (!rst_n)
        done |=> !busy)
        else $error("busy still high the cycle after done");

    //////////////////////////////
    // Ring back-pressure
    //////////////////////////////

    // Stored rows plus the row being pushed leave room for one more read
    no_read_when_full: assert property (@(posedge clk) disable iff (!rst_n)
        mem_rd |-> (int'(count) + int'(push)) < `CONV_RING_ROWS)
        else $error("mem_rd issued while the line ring is full");

endmodule

bind conv_datapath_front conv_dp_front_sva u_sva (
    .clk       (clk),
    .rst_n     (rst_n),
    .mem_rd    (mem_rd),
    .push      (push),
    .count     (count),
    .win_valid (win_valid),
    .done      (done),
    .busy      (busy)
);

//--- rtl/conv_datapath_front.sv
`include "conv_front_settings.svh"

module conv_datapath_front (
    input  logic                      clk,
    input  logic                      rst_n,
    input  logic                      start,
    input  conv_ctrl_pkg::conv_cfg_t  cfg,
    input  conv_types_pkg::row_t      mem_rdata,
    output logic                      mem_rd,
    output logic [`CONV_DIM_BITS-1:0] mem_addr,
    output conv_types_pkg::window_t   win,
    output logic                      win_valid,
    output logic                      busy,
    output logic                      done
);
    import conv_types_pkg::*;
    import conv_ctrl_pkg::*;

    // Run configuration
    conv_cfg_t cfg_q;
    // Start delayed one cycle
    logic go;

    // Fetcher to ring
    logic fetch_issue;
    logic push;
    logic full;
    row_t push_row;

    // Ring to emitter
    logic pop;
    logic [$clog2(`CONV_RING_ROWS)-1:0]   rd_ofs_top, rd_ofs_mid, rd_ofs_bot;
    logic [$clog2(`CONV_RING_ROWS+1)-1:0] count;
    logic [`CONV_DIM_BITS-1:0]            base_row;
    row_t rd_top, rd_mid, rd_bot;

    //////////////////////////////
    // Run control
    //////////////////////////////

    always_ff @(posedge clk) begin
        if (start) begin
            cfg_q <= cfg;
        end
    end

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            go   <= 1'b0;
            busy <= 1'b0;
        end else begin
            go <= start;
            // High from start through the done pulse
            if (start) begin
                busy <= 1'b1;
            end else if (done) begin
                busy <= 1'b0;
            end
        end
    end

    //////////////////////////////
    // Producer, buffer, consumer
    //////////////////////////////

    row_fetch u_fetch (
        .clk         (clk),
        .rst_n       (rst_n),
        .go          (go),
        .cfg         (cfg_q),
        .full        (full),
        .mem_rdata   (mem_rdata),
        .mem_rd      (mem_rd),
        .mem_addr    (mem_addr),
        .fetch_issue (fetch_issue),
        .push        (push),
        .push_row    (push_row)
    );

    line_ring u_ring (
        .clk         (clk),
        .rst_n       (rst_n),
        .go          (go),
        .fetch_issue (fetch_issue),
        .push        (push),
        .push_row    (push_row),
        .pop         (pop),
        .rd_ofs_top  (rd_ofs_top),
        .rd_ofs_mid  (rd_ofs_mid),
        .rd_ofs_bot  (rd_ofs_bot),
        .full        (full),
        .count       (count),
        .base_row    (base_row),
        .rd_top      (rd_top),
        .rd_mid      (rd_mid),
        .rd_bot      (rd_bot)
    );

    window_emit u_emit (
        .clk        (clk),
        .rst_n      (rst_n),
        .go         (go),
        .cfg        (cfg_q),
        .count      (count),
        .base_row   (base_row),
        .rd_top     (rd_top),
        .rd_mid     (rd_mid),
        .rd_bot     (rd_bot),
        .rd_ofs_top (rd_ofs_top),
        .rd_ofs_mid (rd_ofs_mid),
        .rd_ofs_bot (rd_ofs_bot),
        .pop        (pop),
        .win        (win),
        .win_valid  (win_valid),
        .done       (done)
    );

endmodule

//--- rtl/window_emit.sv
`include "conv_front_settings.svh"

module window_emit (
    input  logic                                 clk,
    input  logic                                 rst_n,
    input  logic                                 go,
    input  conv_ctrl_pkg::conv_cfg_t             cfg,
    input  logic [$clog2(`CONV_RING_ROWS+1)-1:0] count,
    input  logic [`CONV_DIM_BITS-1:0]            base_row,
    input  conv_types_pkg::row_t                 rd_top,
    input  conv_types_pkg::row_t                 rd_mid,
    input  conv_types_pkg::row_t                 rd_bot,
    output logic [$clog2(`CONV_RING_ROWS)-1:0]   rd_ofs_top,
    output logic [$clog2(`CONV_RING_ROWS)-1:0]   rd_ofs_mid,
    output logic [$clog2(`CONV_RING_ROWS)-1:0]   rd_ofs_bot,
    output logic                                 pop,
    output conv_types_pkg::window_t              win,
    output logic                                 win_valid,
    output logic                                 done
);
    import conv_types_pkg::*;
    import conv_ctrl_pkg::*;

    // Two extra bits for the sign and the doubled index
    localparam int IDX_W = `CONV_DIM_BITS + 2;
    localparam int OFS_W = $clog2(`CONV_RING_ROWS);
    localparam logic signed [IDX_W-1:0] IDX_ONE = IDX_W'(1);

    emit_state_e state;
    logic [`CONV_DIM_BITS-1:0] out_row;
    logic [`CONV_DIM_BITS:0]   span;
    logic [`CONV_DIM_BITS-1:0] oy;
    logic signed [IDX_W-1:0]   iy_s, base_s, resident_end;
    logic signed [IDX_W-1:0]   top_idx, mid_idx, bot_idx, next_top, hi_real;
    logic                      top_real, mid_real, bot_real, ready, last_win;
    row_t                      top_sel, mid_sel, bot_sel;

    // First input row of output row o, may be -1
    function automatic logic signed [IDX_W-1:0] first_row(
        input logic [`CONV_DIM_BITS-1:0] o,
        input stride_e                   stride,
        input logic                      pad
    );
        logic [IDX_W-1:0] scaled;
        scaled = (stride == stride_two) ? (IDX_W'(o) << 1) : IDX_W'(o);
        return $signed(scaled - IDX_W'(pad));
    endfunction

    //////////////////////////////
    // Window geometry
    //////////////////////////////

    always_comb begin
        // oy = (iy + 2p - 3) / s + 1
        span = {1'b0, cfg.iy} + {{(`CONV_DIM_BITS-1){1'b0}}, cfg.pad, 1'b0}
             - (`CONV_DIM_BITS+1)'(3);
        oy = (cfg.stride == stride_two) ? span[`CONV_DIM_BITS:1] + 1'b1
                                        : span[`CONV_DIM_BITS-1:0] + 1'b1;
        last_win = (out_row == oy - 1'b1);
        iy_s = $signed(IDX_W'(cfg.iy));
        base_s = $signed(IDX_W'(base_row));
        resident_end = $signed(IDX_W'(base_row) + IDX_W'(count));
        top_idx = first_row(out_row, cfg.stride, cfg.pad);
        mid_idx = top_idx + IDX_ONE;
        bot_idx = mid_idx + IDX_ONE;
        next_top = first_row(out_row + 1'b1, cfg.stride, cfg.pad);
        // Rows outside 0..iy-1 read as zero
        top_real = !top_idx[IDX_W-1] && (top_idx < iy_s);
        mid_real = !mid_idx[IDX_W-1] && (mid_idx < iy_s);
        bot_real = !bot_idx[IDX_W-1] && (bot_idx < iy_s);
        // Bottom real row decides residency
        hi_real = bot_real ? bot_idx : iy_s - IDX_ONE;
        ready = (state == e_check) && (hi_real < resident_end);
        top_sel = top_real ? rd_top : '0;
        mid_sel = mid_real ? rd_mid : '0;
        bot_sel = bot_real ? rd_bot : '0;
    end

    // Slot offsets from the oldest resident row
    assign rd_ofs_top = OFS_W'(top_idx - base_s);
    assign rd_ofs_mid = OFS_W'(mid_idx - base_s);
    assign rd_ofs_bot = OFS_W'(bot_idx - base_s);

    // Drop rows above the next window, never a padding row
    assign pop = (state == e_retire) && (base_s < next_top) && (count != '0);

    //////////////////////////////
    // Emit FSM
    //////////////////////////////

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            state     <= e_idle;
            out_row   <= '0;
            win_valid <= 1'b0;
            done      <= 1'b0;
        end else begin
            win_valid <= 1'b0;
            done      <= 1'b0;
            case (state)
                e_idle: begin
                    if (go) begin
                        out_row <= '0;
                        state   <= e_check;
                    end
                end
                e_check: begin
                    // All real rows resident
                    if (ready) begin
                        win_valid <= 1'b1;
                        state     <= last_win ? e_done : e_retire;
                    end
                end
                e_retire: begin
                    // One pop per cycle until the next window's top
                    if (!pop) begin
                        out_row <= out_row + 1'b1;
                        state   <= e_check;
                    end
                end
                e_done: begin
                    // Cycle after the last window
                    done  <= 1'b1;
                    state <= e_idle;
                end
                default: begin
                    state <= e_idle;
                end
            endcase
        end
    end

    // Window payload
    always_ff @(posedge clk) begin
        if (ready) begin
            win.top     <= top_sel;
            win.mid     <= mid_sel;
            win.bot     <= bot_sel;
            win.out_row <= out_row;
        end
    end

endmodule

//--- rtl/line_ring.sv
`include "conv_front_settings.svh"

module line_ring (
    input  logic                                 clk,
    input  logic                                 rst_n,
    input  logic                                 go,
    input  logic                                 fetch_issue,
    input  logic                                 push,
    input  conv_types_pkg::row_t                 push_row,
    input  logic                                 pop,
    input  logic [$clog2(`CONV_RING_ROWS)-1:0]   rd_ofs_top,
    input  logic [$clog2(`CONV_RING_ROWS)-1:0]   rd_ofs_mid,
    input  logic [$clog2(`CONV_RING_ROWS)-1:0]   rd_ofs_bot,
    output logic                                 full,
    output logic [$clog2(`CONV_RING_ROWS+1)-1:0] count,
    output logic [`CONV_DIM_BITS-1:0]            base_row,
    output conv_types_pkg::row_t                 rd_top,
    output conv_types_pkg::row_t                 rd_mid,
    output conv_types_pkg::row_t                 rd_bot
);
    import conv_types_pkg::*;

    localparam int SLOTS = `CONV_RING_ROWS;
    localparam int PTR_W = $clog2(SLOTS);
    localparam int CNT_W = $clog2(SLOTS + 1);

    // Row storage
    row_t slots [SLOTS];

    // Write slot and oldest slot
    logic [PTR_W-1:0] wr_ptr;
    logic [PTR_W-1:0] rd_ptr;

    // Read issued last cycle, push arrives this cycle
    logic in_flight;

    // Slot index plus offset, wrapping at SLOTS
    function automatic logic [PTR_W-1:0] slot_add(
        input logic [PTR_W-1:0] ptr,
        input logic [PTR_W-1:0] ofs
    );
        logic [PTR_W:0] sum;
        sum = {1'b0, ptr} + {1'b0, ofs};
        if (sum >= (PTR_W+1)'(SLOTS)) begin
            sum = sum - (PTR_W+1)'(SLOTS);
        end
        return sum[PTR_W-1:0];
    endfunction

    //////////////////////////////
    // Occupancy
    //////////////////////////////

    // No room for one more read
    assign full = ({1'b0, count} + (CNT_W+1)'(in_flight)) >= (CNT_W+1)'(SLOTS);

    always_ff @(posedge clk) begin
        if (!rst_n || go) begin
            // New run starts empty
            wr_ptr    <= '0;
            rd_ptr    <= '0;
            count     <= '0;
            base_row  <= '0;
            in_flight <= 1'b0;
        end else begin
            in_flight <= fetch_issue;
            if (push) begin
                wr_ptr <= slot_add(wr_ptr, PTR_W'(1));
            end
            if (pop) begin
                rd_ptr   <= slot_add(rd_ptr, PTR_W'(1));
                // Oldest row moves down the map
                base_row <= base_row + 1'b1;
            end
            count <= count + CNT_W'(push) - CNT_W'(pop);
        end
    end

    //////////////////////////////
    // Storage and reads
    //////////////////////////////

    always_ff @(posedge clk) begin
        if (push && !go) begin
            slots[wr_ptr] <= push_row;
        end
    end

    // Offsets count from the oldest row
    assign rd_top = slots[slot_add(rd_ptr, rd_ofs_top)];
    assign rd_mid = slots[slot_add(rd_ptr, rd_ofs_mid)];
    assign rd_bot = slots[slot_add(rd_ptr, rd_ofs_bot)];

endmodule

//--- rtl/row_fetch.sv
`include "conv_front_settings.svh"

module row_fetch (
    input  logic                      clk,
    input  logic                      rst_n,
    input  logic                      go,
    input  conv_ctrl_pkg::conv_cfg_t  cfg,
    input  logic                      full,
    input  conv_types_pkg::row_t      mem_rdata,
    output logic                      mem_rd,
    output logic [`CONV_DIM_BITS-1:0] mem_addr,
    output logic                      fetch_issue,
    output logic                      push,
    output conv_types_pkg::row_t      push_row
);
    import conv_ctrl_pkg::*;

    fetch_state_e state;

    // Next row index to read
    logic [`CONV_DIM_BITS-1:0] next_row;

    // Current read is the bottom row of the map
    logic last_row;

    //////////////////////////////
    // Read request
    //////////////////////////////

    // One read per cycle whenever the ring has room
    // No read in the go cycle, the run is restarting
    assign mem_rd = (state != f_idle) && !full && !go;
    assign mem_addr = next_row;

    // Ring counts this as the read in flight
    assign fetch_issue = mem_rd;

    assign last_row = (next_row == cfg.iy - 1'b1);

    //////////////////////////////
    // Fetch FSM
    //////////////////////////////

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            state    <= f_idle;
            next_row <= '0;
        end else if (go) begin
            // Restart from row 0
            state    <= f_issue;
            next_row <= '0;
        end else begin
            case (state)
                f_idle: begin
                    state <= f_idle;
                end
                f_issue, f_wait_space: begin
                    if (mem_rd) begin
                        next_row <= next_row + 1'b1;
                        // All rows read
                        if (last_row) begin
                            state <= f_idle;
                        end else begin
                            state <= f_issue;
                        end
                    end else begin
                        // Ring full, hold the row index
                        state <= f_wait_space;
                    end
                end
                default: begin
                    state <= f_idle;
                end
            endcase
        end
    end

    //////////////////////////////
    // Push to ring
    //////////////////////////////

    // Memory answers one cycle after the read
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            push <= 1'b0;
        end else begin
            push <= mem_rd;
        end
    end

    // Returned word goes straight into the ring slot
    assign push_row = mem_rdata;

endmodule

//--- rtl/conv_ctrl_pkg.sv
`include "conv_front_settings.svh"

package conv_ctrl_pkg;

    //////////////////////////////
    // Run configuration
    //////////////////////////////

    // Vertical stride
    typedef enum logic {
        stride_one = 1'b0,
        stride_two = 1'b1
    } stride_e;

    // Latched on start
    typedef struct packed {
        logic [`CONV_DIM_BITS-1:0] iy;
        stride_e                   stride;
        // Zero rows above and below
        logic                      pad;
    } conv_cfg_t;

    //////////////////////////////
    // Control FSMs
    //////////////////////////////

    // Row fetcher
    typedef enum logic [1:0] {
        f_idle,
        f_issue,
        f_wait_space
    } fetch_state_e;

    // Window emitter
    typedef enum logic [1:0] {
        e_idle,
        e_check,
        e_retire,
        e_done
    } emit_state_e;

endpackage

//--- rtl/conv_types_pkg.sv
`include "conv_front_settings.svh"

package conv_types_pkg;

    //////////////////////////////
    // Datapath payload types
    //////////////////////////////

    // Single pixel
    typedef logic [`CONV_PIXEL_BITS-1:0] pixel_t;

    // Full memory word, pixel 0 in the low bits
    typedef pixel_t [`CONV_ROW_PIXELS-1:0] row_t;

    // Vertical 3-row window for the array
    typedef struct packed {
        // Row o*s - p
        row_t top;
        // Row o*s - p + 1
        row_t mid;
        // Row o*s - p + 2
        row_t bot;
        // Output row index o
        logic [`CONV_DIM_BITS-1:0] out_row;
    } window_t;

endpackage

//--- rtl/conv_front_settings.svh
`ifndef CONV_FRONT_SETTINGS_SVH
`define CONV_FRONT_SETTINGS_SVH

//////////////////////////////
// Pixel and row geometry
//////////////////////////////

// Bits per pixel
`define CONV_PIXEL_BITS 8

// Pixels in one memory word
`define CONV_ROW_PIXELS 32

//////////////////////////////
// Counters and buffering
//////////////////////////////

// Height and row index width
`define CONV_DIM_BITS 16

// Three window rows plus one in fill
`define CONV_RING_ROWS 4

`endif
